// File: rtl/alu_pkg.sv
package alu_pkg;

   // ==================================================================
   // Datapath sizing.
   // ==================================================================
   localparam int XLEN       = 32;
   localparam int CNT_W      = 5;
   // Start edge to done edge: two passes plus one edge for the output latch.
   localparam int OP_LATENCY = 65;

   // ==================================================================
   // Request encodings.
   // ==================================================================
   localparam logic [3:0] OP_ADD  = 4'd0;
   localparam logic [3:0] OP_SUB  = 4'd1;
   localparam logic [3:0] OP_SLT  = 4'd2;
   localparam logic [3:0] OP_SLTU = 4'd3;
   localparam logic [3:0] OP_XOR  = 4'd4;
   localparam logic [3:0] OP_OR   = 4'd5;
   localparam logic [3:0] OP_AND  = 4'd6;
   localparam logic [3:0] OP_SLL  = 4'd7;
   localparam logic [3:0] OP_SRL  = 4'd8;
   localparam logic [3:0] OP_SRA  = 4'd9;

   // Branch conditions, funct3 style.
   localparam logic [2:0] CND_EQ  = 3'd0;
   localparam logic [2:0] CND_NE  = 3'd1;
   localparam logic [2:0] CND_LT  = 3'd4;
   localparam logic [2:0] CND_GE  = 3'd5;
   localparam logic [2:0] CND_LTU = 3'd6;
   localparam logic [2:0] CND_GEU = 3'd7;

   // ==================================================================
   // Internal ALU controls.
   // ==================================================================
   localparam logic [1:0] RES_ADD   = 2'd0;
   localparam logic [1:0] RES_SHIFT = 2'd1;
   localparam logic [1:0] RES_LT    = 2'd2;
   localparam logic [1:0] RES_BOOL  = 2'd3;

   localparam logic [1:0] BOOL_AND = 2'd0;
   localparam logic [1:0] BOOL_OR  = 2'd1;
   localparam logic [1:0] BOOL_EQ  = 2'd2;
   localparam logic [1:0] BOOL_XOR = 2'd3;
   // One nibble per boolean code, indexed by {a, b}.
   localparam logic [15:0] BOOL_LUT = 16'h69E8;

   localparam logic CMP_EQ = 1'b0;
   localparam logic CMP_LT = 1'b1;

endpackage

// File: rtl/operand_serializer.sv
module operand_serializer (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_start,
   input  logic                     i_shift,
   input  logic [alu_pkg::XLEN-1:0] i_rs1,
   input  logic [alu_pkg::XLEN-1:0] i_op_b,
   output logic                     o_rs1_bit,
   output logic                     o_op_b_bit
);

   logic [alu_pkg::XLEN-1:0] rs1_r;
   logic [alu_pkg::XLEN-1:0] op_b_r;

   // Rotate right so a full pass restores the word for the next pass.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         rs1_r  <= '0;
         op_b_r <= '0;
      end else if (i_shift) begin
         rs1_r  <= {rs1_r[0], rs1_r[alu_pkg::XLEN-1:1]};
         op_b_r <= {op_b_r[0], op_b_r[alu_pkg::XLEN-1:1]};
      end else if (i_start) begin
         // A start during a pass is dropped.
         rs1_r  <= i_rs1;
         op_b_r <= i_op_b;
      end
   end

   // LSB first.
   assign o_rs1_bit  = rs1_r[0];
   assign o_op_b_bit = op_b_r[0];

endmodule

// File: rtl/alu_sequencer.sv
module alu_sequencer (
   input  logic                      clk,
   input  logic                      i_reset,
   input  logic                      i_start,
   input  logic [3:0]                i_op,
   input  logic [2:0]                i_cond,
   output logic                      o_busy,
   output logic                      o_init,
   output logic                      o_en,
   output logic                      o_cnt_done,
   output logic                      o_last_bit,
   output logic [alu_pkg::CNT_W-1:0] o_cnt,
   output logic                      o_sub,
   output logic [1:0]                o_bool_op,
   output logic [1:0]                o_rd_sel,
   output logic                      o_cmp_sel,
   output logic                      o_cmp_neg,
   output logic                      o_cmp_uns,
   output logic                      o_sh_right,
   output logic                      o_sh_signed
);

   logic                      init_r;
   logic                      en_r;
   logic                      fin_r;
   logic [alu_pkg::CNT_W-1:0] cnt_r;
   logic                      start_ok;
   logic                      fin_done;

   logic       sub_d;
   logic [1:0] bool_d;
   logic [1:0] rd_sel_d;
   logic       cmp_sel_d;
   logic       cmp_neg_d;
   logic       cmp_uns_d;
   logic       sh_right_d;
   logic       sh_signed_d;

   assign o_busy     = init_r | en_r | fin_r;
   assign o_init     = init_r;
   assign o_en       = en_r;
   assign o_cnt      = cnt_r;
   assign o_cnt_done = (init_r | en_r) && (cnt_r == alu_pkg::CNT_W'(alu_pkg::XLEN - 1));
   assign o_last_bit = o_cnt_done & en_r;

   assign start_ok = i_start & ~o_busy;
   // Tail after the run pass covers the output latch edge.
   assign fin_done = fin_r &&
      (cnt_r == alu_pkg::CNT_W'(alu_pkg::OP_LATENCY - 2 * alu_pkg::XLEN - 1));

   // ==================================================================
   // Pass sequencing.
   // ==================================================================
   always_ff @(posedge clk) begin
      if (i_reset) begin
         init_r <= 1'b0;
         en_r   <= 1'b0;
         fin_r  <= 1'b0;
         cnt_r  <= '0;
      end else begin
         init_r <= start_ok | (init_r & ~o_cnt_done);
         en_r   <= (init_r & o_cnt_done) | (en_r & ~o_cnt_done);
         fin_r  <= (en_r & o_cnt_done) | (fin_r & ~fin_done);
         if (~o_busy | fin_done)
            cnt_r <= '0;
         else
            cnt_r <= cnt_r + 1'b1;
      end
   end

   // ==================================================================
   // Operation and condition decode.
   // ==================================================================
   always_comb begin
      sub_d       = 1'b0;
      bool_d      = alu_pkg::BOOL_AND;
      rd_sel_d    = alu_pkg::RES_ADD;
      sh_right_d  = 1'b0;
      sh_signed_d = 1'b0;
      cmp_sel_d   = alu_pkg::CMP_EQ;
      cmp_neg_d   = 1'b0;
      cmp_uns_d   = 1'b0;
      case (i_cond)
         alu_pkg::CND_NE:  cmp_neg_d = 1'b1;
         alu_pkg::CND_LT:  cmp_sel_d = alu_pkg::CMP_LT;
         alu_pkg::CND_GE: begin
            cmp_sel_d = alu_pkg::CMP_LT;
            cmp_neg_d = 1'b1;
         end
         alu_pkg::CND_LTU: begin
            cmp_sel_d = alu_pkg::CMP_LT;
            cmp_uns_d = 1'b1;
         end
         alu_pkg::CND_GEU: begin
            cmp_sel_d = alu_pkg::CMP_LT;
            cmp_neg_d = 1'b1;
            cmp_uns_d = 1'b1;
         end
         default: ;
      endcase
      case (i_op)
         alu_pkg::OP_SUB:  sub_d = 1'b1;
         alu_pkg::OP_SLT: begin
            rd_sel_d  = alu_pkg::RES_LT;
            cmp_uns_d = 1'b0;
         end
         alu_pkg::OP_SLTU: begin
            rd_sel_d  = alu_pkg::RES_LT;
            cmp_uns_d = 1'b1;
         end
         alu_pkg::OP_XOR: begin
            rd_sel_d = alu_pkg::RES_BOOL;
            bool_d   = alu_pkg::BOOL_XOR;
         end
         alu_pkg::OP_OR: begin
            rd_sel_d = alu_pkg::RES_BOOL;
            bool_d   = alu_pkg::BOOL_OR;
         end
         alu_pkg::OP_AND:  rd_sel_d = alu_pkg::RES_BOOL;
         alu_pkg::OP_SLL:  rd_sel_d = alu_pkg::RES_SHIFT;
         alu_pkg::OP_SRL: begin
            rd_sel_d   = alu_pkg::RES_SHIFT;
            sh_right_d = 1'b1;
         end
         alu_pkg::OP_SRA: begin
            rd_sel_d    = alu_pkg::RES_SHIFT;
            sh_right_d  = 1'b1;
            sh_signed_d = 1'b1;
         end
         default: ;
      endcase
   end

   // Held until the next accepted start.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_sub       <= 1'b0;
         o_bool_op   <= alu_pkg::BOOL_AND;
         o_rd_sel    <= alu_pkg::RES_ADD;
         o_cmp_sel   <= alu_pkg::CMP_EQ;
         o_cmp_neg   <= 1'b0;
         o_cmp_uns   <= 1'b0;
         o_sh_right  <= 1'b0;
         o_sh_signed <= 1'b0;
      end else if (start_ok) begin
         o_sub       <= sub_d;
         o_bool_op   <= bool_d;
         o_rd_sel    <= rd_sel_d;
         o_cmp_sel   <= cmp_sel_d;
         o_cmp_neg   <= cmp_neg_d;
         o_cmp_uns   <= cmp_uns_d;
         o_sh_right  <= sh_right_d;
         o_sh_signed <= sh_signed_d;
      end
   end

endmodule

// File: rtl/ser_add.sv
module ser_add (
   input  logic clk,
   input  logic i_reset,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q,
   output logic o_v
);

   logic carry_r;

   assign o_q = i_a ^ i_b ^ carry_r;
   assign o_v = (i_a & i_b) | (carry_r & (i_a ^ i_b));

   // Carry chains across cycles.
   always_ff @(posedge clk) begin
      if (i_reset | i_clr)
         carry_r <= 1'b0;
      else
         carry_r <= o_v;
   end

endmodule

// File: rtl/ser_shift.sv
module ser_shift (
   input  logic                      clk,
   input  logic                      i_reset,
   input  logic                      i_init,
   input  logic                      i_en,
   input  logic                      i_d,
   input  logic                      i_shamt_bit,
   input  logic [alu_pkg::CNT_W-1:0] i_cnt,
   input  logic                      i_right,
   input  logic                      i_signed,
   output logic                      o_q
);

   logic [alu_pkg::XLEN-1:0]  buf_r;
   logic [alu_pkg::CNT_W-1:0] shamt_r;
   logic [alu_pkg::CNT_W:0]   r_idx;
   logic [alu_pkg::CNT_W-1:0] l_idx;
   logic                      fill;
   logic                      r_bit;
   logic                      l_bit;

   // Source word fills LSB first over the init pass.
   always_ff @(posedge clk) begin
      if (i_init)
         buf_r <= {i_d, buf_r[alu_pkg::XLEN-1:1]};
   end

   // Amount is op_b bits 0 to 4.
   always_ff @(posedge clk) begin
      if (i_reset)
         shamt_r <= '0;
      else if (i_init && (i_cnt < alu_pkg::CNT_W'(alu_pkg::CNT_W)))
         shamt_r <= {i_shamt_bit, shamt_r[alu_pkg::CNT_W-1:1]};
   end

   // Top bit of the buffer is the source sign after init.
   assign fill = i_signed & buf_r[alu_pkg::XLEN-1];

   assign r_idx = {1'b0, i_cnt} + {1'b0, shamt_r};
   assign r_bit = r_idx[alu_pkg::CNT_W] ? fill : buf_r[r_idx[alu_pkg::CNT_W-1:0]];

   assign l_idx = i_cnt - shamt_r;
   assign l_bit = (i_cnt < shamt_r) ? 1'b0 : buf_r[l_idx];

   assign o_q = i_en & (i_right ? r_bit : l_bit);

endmodule

// File: rtl/serial_alu.sv
module serial_alu (
   input  logic                      clk,
   input  logic                      i_reset,
   input  logic                      i_init,
   input  logic                      i_en,
   input  logic                      i_cnt_done,
   input  logic                      i_rs1,
   input  logic                      i_op_b,
   input  logic                      i_sub,
   input  logic [1:0]                i_bool_op,
   input  logic [1:0]                i_rd_sel,
   input  logic                      i_cmp_sel,
   input  logic                      i_cmp_neg,
   input  logic                      i_cmp_uns,
   input  logic                      i_sh_right,
   input  logic                      i_sh_signed,
   input  logic [alu_pkg::CNT_W-1:0] i_cnt,
   output logic                      o_rd,
   output logic                      o_cmp
);

   logic first_bit;
   logic plus_1;
   logic b_neg;
   logic add_b;
   logic result_add;
   logic result_sh;
   logic result_bool;
   logic result_lt;
   logic lt_in;
   logic lt_bit;
   logic eq_bit;
   logic sign_bit;
   logic lt_r;
   logic eq_r;

   assign first_bit = (i_cnt == '0);

   // ==================================================================
   // Adder path; -b is ~b plus one injected on the first run bit.
   // ==================================================================
   assign plus_1 = i_en & first_bit;

   ser_add u_neg (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (~i_op_b),
      .i_b     (plus_1),
      .i_clr   (~i_en),
      .o_q     (b_neg),
      .o_v     ()
   );

   assign add_b = i_sub ? b_neg : i_op_b;

   ser_add u_add (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (i_rs1),
      .i_b     (add_b),
      .i_clr   (~i_en),
      .o_q     (result_add),
      .o_v     ()
   );

   ser_shift u_shift (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_init      (i_init),
      .i_en        (i_en),
      .i_d         (i_rs1),
      .i_shamt_bit (i_op_b),
      .i_cnt       (i_cnt),
      .i_right     (i_sh_right),
      .i_signed    (i_sh_signed),
      .o_q         (result_sh)
   );

   // ==================================================================
   // Compare over the init pass; higher bits override lower ones.
   // ==================================================================
   assign sign_bit = i_cnt_done & ~i_cmp_uns;
   assign lt_in    = ~first_bit & lt_r;
   assign lt_bit   = sign_bit ? ((i_rs1 & ~i_op_b) | (~(i_rs1 ^ i_op_b) & lt_in))
                              : ((~i_rs1 & i_op_b) | (~(i_rs1 ^ i_op_b) & lt_in));
   assign eq_bit   = (i_rs1 == i_op_b) & (first_bit | eq_r);

   // Final values settle at cnt_done and hold through run.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         lt_r <= 1'b0;
         eq_r <= 1'b0;
      end else if (i_init) begin
         lt_r <= lt_bit;
         eq_r <= eq_bit;
      end
   end

   assign o_cmp = i_cmp_neg ^ ((i_cmp_sel == alu_pkg::CMP_EQ) ? eq_r : lt_r);

   assign result_lt   = lt_r & first_bit;
   assign result_bool = alu_pkg::BOOL_LUT[{i_bool_op, i_rs1, i_op_b}];

   always_comb begin
      case (i_rd_sel)
         alu_pkg::RES_ADD:   o_rd = result_add;
         alu_pkg::RES_SHIFT: o_rd = result_sh;
         alu_pkg::RES_LT:    o_rd = result_lt;
         default:            o_rd = result_bool;
      endcase
   end

endmodule

// File: rtl/result_collector.sv
module result_collector (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_en,
   input  logic                     i_last_bit,
   input  logic                     i_rd,
   input  logic                     i_cmp,
   output logic                     o_done,
   output logic [alu_pkg::XLEN-1:0] o_result,
   output logic                     o_cmp
);

   logic [alu_pkg::XLEN-1:0] sh_r;
   logic                     pend_r;

   // LSB arrives first, so bits move down from the top.
   always_ff @(posedge clk) begin
      if (i_en)
         sh_r <= {i_rd, sh_r[alu_pkg::XLEN-1:1]};
   end

   // Word is complete one edge after the last bit.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pend_r   <= 1'b0;
         o_done   <= 1'b0;
         o_result <= '0;
         o_cmp    <= 1'b0;
      end else begin
         pend_r <= i_last_bit;
         o_done <= pend_r;
         if (pend_r) begin
            o_result <= sh_r;
            o_cmp    <= i_cmp;
         end
      end
   end

endmodule

// File: rtl/serial_alu_top.sv
module serial_alu_top (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_start,
   input  logic [alu_pkg::XLEN-1:0] i_rs1,
   input  logic [alu_pkg::XLEN-1:0] i_op_b,
   input  logic [3:0]               i_op,
   input  logic [2:0]               i_cond,
   output logic                     o_busy,
   output logic                     o_done,
   output logic [alu_pkg::XLEN-1:0] o_result,
   output logic                     o_cmp
);

   logic                      init;
   logic                      en;
   logic                      cnt_done;
   logic                      last_bit;
   logic [alu_pkg::CNT_W-1:0] cnt;
   logic                      sub;
   logic [1:0]                bool_op;
   logic [1:0]                rd_sel;
   logic                      cmp_sel;
   logic                      cmp_neg;
   logic                      cmp_uns;
   logic                      sh_right;
   logic                      sh_signed;
   logic                      rs1_bit;
   logic                      op_b_bit;
   logic                      rd;
   logic                      cmp;

   operand_serializer u_ser (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_start    (i_start),
      .i_shift    (init | en),
      .i_rs1      (i_rs1),
      .i_op_b     (i_op_b),
      .o_rs1_bit  (rs1_bit),
      .o_op_b_bit (op_b_bit)
   );

   alu_sequencer u_seq (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_start     (i_start),
      .i_op        (i_op),
      .i_cond      (i_cond),
      .o_busy      (o_busy),
      .o_init      (init),
      .o_en        (en),
      .o_cnt_done  (cnt_done),
      .o_last_bit  (last_bit),
      .o_cnt       (cnt),
      .o_sub       (sub),
      .o_bool_op   (bool_op),
      .o_rd_sel    (rd_sel),
      .o_cmp_sel   (cmp_sel),
      .o_cmp_neg   (cmp_neg),
      .o_cmp_uns   (cmp_uns),
      .o_sh_right  (sh_right),
      .o_sh_signed (sh_signed)
   );

   serial_alu u_alu (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_init      (init),
      .i_en        (en),
      .i_cnt_done  (cnt_done),
      .i_rs1       (rs1_bit),
      .i_op_b      (op_b_bit),
      .i_sub       (sub),
      .i_bool_op   (bool_op),
      .i_rd_sel    (rd_sel),
      .i_cmp_sel   (cmp_sel),
      .i_cmp_neg   (cmp_neg),
      .i_cmp_uns   (cmp_uns),
      .i_sh_right  (sh_right),
      .i_sh_signed (sh_signed),
      .i_cnt       (cnt),
      .o_rd        (rd),
      .o_cmp       (cmp)
   );

   result_collector u_col (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_en       (en),
      .i_last_bit (last_bit),
      .i_rd       (rd),
      .i_cmp      (cmp),
      .o_done     (o_done),
      .o_result   (o_result),
      .o_cmp      (o_cmp)
   );

endmodule

// File: sim/alu_checker.sv
module alu_checker (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_start,
   input  logic [alu_pkg::XLEN-1:0] i_rs1,
   input  logic [alu_pkg::XLEN-1:0] i_op_b,
   input  logic [3:0]               i_op,
   input  logic [2:0]               i_cond,
   input  logic                     i_busy,
   input  logic                     i_done,
   input  logic [alu_pkg::XLEN-1:0] i_result,
   input  logic                     i_cmp,
   output int                       o_pass_cnt,
   output int                       o_fail_cnt
);
   timeunit 1ns;
   timeprecision 100ps;

   logic                     pending;
   logic                     reset_seen;
   int                       age;
   int                       test_idx;
   int                       errs;
   int                       fails_before;
   logic [3:0]               req_op;
   logic [2:0]               req_cond;
   logic [alu_pkg::XLEN-1:0] req_a;
   logic [alu_pkg::XLEN-1:0] req_b;
   logic [alu_pkg::XLEN-1:0] last_result;
   logic                     last_cmp;

   // ==================================================================
   // Reference model.
   // ==================================================================
   function automatic logic [31:0] model_result(input logic [3:0] op,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
      logic [4:0] sh;
      sh = b[4:0];
      case (op)
         alu_pkg::OP_ADD:  return a + b;
         alu_pkg::OP_SUB:  return a - b;
         alu_pkg::OP_SLT:  return {31'd0, ($signed(a) < $signed(b))};
         alu_pkg::OP_SLTU: return {31'd0, (a < b)};
         alu_pkg::OP_XOR:  return a ^ b;
         alu_pkg::OP_OR:   return a | b;
         alu_pkg::OP_AND:  return a & b;
         alu_pkg::OP_SLL:  return a << sh;
         alu_pkg::OP_SRL:  return a >> sh;
         alu_pkg::OP_SRA:  return $signed(a) >>> sh;
         default:          return 32'd0;
      endcase
   endfunction

   // SLT and SLTU force the signedness of the branch compare.
   function automatic logic model_branch(input logic [3:0] op, input logic [2:0] cond,
                                         input logic [31:0] a, input logic [31:0] b);
      logic uns;
      logic lt;
      uns = (cond == alu_pkg::CND_LTU) || (cond == alu_pkg::CND_GEU);
      if (op == alu_pkg::OP_SLT)
         uns = 1'b0;
      else if (op == alu_pkg::OP_SLTU)
         uns = 1'b1;
      lt = uns ? (a < b) : ($signed(a) < $signed(b));
      case (cond)
         alu_pkg::CND_EQ:  return a == b;
         alu_pkg::CND_NE:  return a != b;
         alu_pkg::CND_LT,
         alu_pkg::CND_LTU: return lt;
         alu_pkg::CND_GE,
         alu_pkg::CND_GEU: return !lt;
         default:          return 1'b0;
      endcase
   endfunction

   function automatic string op_name(input logic [3:0] op);
      case (op)
         alu_pkg::OP_ADD:  return "ADD";
         alu_pkg::OP_SUB:  return "SUB";
         alu_pkg::OP_SLT:  return "SLT";
         alu_pkg::OP_SLTU: return "SLTU";
         alu_pkg::OP_XOR:  return "XOR";
         alu_pkg::OP_OR:   return "OR";
         alu_pkg::OP_AND:  return "AND";
         alu_pkg::OP_SLL:  return "SLL";
         alu_pkg::OP_SRL:  return "SRL";
         alu_pkg::OP_SRA:  return "SRA";
         default:          return "???";
      endcase
   endfunction

   // ==================================================================
   // Comparison helpers.
   // ==================================================================
   task automatic note_error();
      if (pending)
         errs++;
      else
         o_fail_cnt++;
   endtask

   task automatic compare_word(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, got %h", name, expected, actual);
         note_error();
      end
   endtask

   task automatic finish_test();
      logic [31:0] exp_result;
      logic        exp_cmp;
      exp_result = model_result(req_op, req_a, req_b);
      exp_cmp    = model_branch(req_op, req_cond, req_a, req_b);
      if (i_done !== 1'b1) begin
         $display("No done pulse %0d edges after start", alu_pkg::OP_LATENCY);
         note_error();
      end else begin
         compare_word("o_result", exp_result, i_result);
         compare_word("o_cmp", {31'd0, exp_cmp}, {31'd0, i_cmp});
         compare_word("o_busy", 32'd0, {31'd0, i_busy});
      end
      last_result = i_result;
      last_cmp    = i_cmp;
      $display("test %0d %s rs1=%h op_b=%h cond=%0d: %s", test_idx, op_name(req_op),
               req_a, req_b, req_cond, (errs == 0) ? "ok" : "failed");
      if (errs == 0)
         o_pass_cnt++;
      else
         o_fail_cnt++;
      test_idx++;
      pending = 1'b0;
   endtask

   // Inputs are sampled before the edge updates them.
   always @(posedge clk) begin
      if (i_reset) begin
         pending     = 1'b0;
         reset_seen  = 1'b1;
         age         = 0;
         test_idx    = 0;
         errs        = 0;
         last_result = '0;
         last_cmp    = 1'b0;
         o_pass_cnt  = 0;
         o_fail_cnt  = 0;
      end else begin
         if (reset_seen) begin
            reset_seen   = 1'b0;
            fails_before = o_fail_cnt;
            compare_word("o_busy", 32'd0, {31'd0, i_busy});
            compare_word("o_done", 32'd0, {31'd0, i_done});
            compare_word("o_result", 32'd0, i_result);
            compare_word("o_cmp", 32'd0, {31'd0, i_cmp});
            $display("reset state: %s", (o_fail_cnt == fails_before) ? "ok" : "failed");
         end
         if (pending) begin
            age++;
            if (age <= alu_pkg::OP_LATENCY) begin
               if (i_done !== 1'b0) begin
                  $display("Done came early, %0d edges after start", age - 1);
                  note_error();
               end
               if (i_busy !== 1'b1) begin
                  $display("Busy dropped %0d edges after start", age - 1);
                  note_error();
               end
            end else begin
               finish_test();
            end
         end else begin
            if (i_done === 1'b1) begin
               $display("Done pulse with no request in flight");
               note_error();
            end
            if (i_busy === 1'b1) begin
               $display("Busy high with no request in flight");
               note_error();
            end
         end
         if (i_done !== 1'b1) begin
            compare_word("o_result", last_result, i_result);
            compare_word("o_cmp", {31'd0, last_cmp}, {31'd0, i_cmp});
         end
         if (i_start && !i_busy) begin
            pending  = 1'b1;
            age      = 0;
            errs     = 0;
            req_op   = i_op;
            req_cond = i_cond;
            req_a    = i_rs1;
            req_b    = i_op_b;
         end
      end
   end

endmodule

// File: sim/tb_serial_alu.sv
module tb_serial_alu;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 10;
   localparam int N_DIRECTED   = 24;
   localparam int N_RANDOM     = 200;
   localparam int N_TESTS      = N_DIRECTED + N_RANDOM;
   localparam int MAX_CYCLES   = N_TESTS * (alu_pkg::OP_LATENCY + 4) + RESET_CYCLES;

   logic                     clk;
   logic                     i_reset;
   logic                     i_start;
   logic [alu_pkg::XLEN-1:0] i_rs1;
   logic [alu_pkg::XLEN-1:0] i_op_b;
   logic [3:0]               i_op;
   logic [2:0]               i_cond;
   logic                     o_busy;
   logic                     o_done;
   logic [alu_pkg::XLEN-1:0] o_result;
   logic                     o_cmp;
   int                       pass_cnt;
   int                       fail_cnt;
   int                       issued;
   int                       cycles;
   logic [31:0]              rng_state;

   serial_alu_top dut_i (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_start  (i_start),
      .i_rs1    (i_rs1),
      .i_op_b   (i_op_b),
      .i_op     (i_op),
      .i_cond   (i_cond),
      .o_busy   (o_busy),
      .o_done   (o_done),
      .o_result (o_result),
      .o_cmp    (o_cmp)
   );

   alu_checker u_checker (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_start    (i_start),
      .i_rs1      (i_rs1),
      .i_op_b     (i_op_b),
      .i_op       (i_op),
      .i_cond     (i_cond),
      .i_busy     (o_busy),
      .i_done     (o_done),
      .i_result   (o_result),
      .i_cmp      (o_cmp),
      .o_pass_cnt (pass_cnt),
      .o_fail_cnt (fail_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [3:0] op_from_index(input int idx);
      case (idx)
         0:       return alu_pkg::OP_ADD;
         1:       return alu_pkg::OP_SUB;
         2:       return alu_pkg::OP_SLT;
         3:       return alu_pkg::OP_SLTU;
         4:       return alu_pkg::OP_XOR;
         5:       return alu_pkg::OP_OR;
         6:       return alu_pkg::OP_AND;
         7:       return alu_pkg::OP_SLL;
         8:       return alu_pkg::OP_SRL;
         default: return alu_pkg::OP_SRA;
      endcase
   endfunction

   function automatic logic [2:0] cond_from_index(input int idx);
      case (idx)
         0:       return alu_pkg::CND_EQ;
         1:       return alu_pkg::CND_NE;
         2:       return alu_pkg::CND_LT;
         3:       return alu_pkg::CND_GE;
         4:       return alu_pkg::CND_LTU;
         default: return alu_pkg::CND_GEU;
      endcase
   endfunction

   // Called 1 ns after an edge; returns 1 ns after the done edge.
   task automatic await_done();
      do begin
         @(posedge clk);
         #1;
      end while (o_done !== 1'b1);
   endtask

   task automatic issue_request(input logic [3:0] op, input logic [2:0] cond,
                                input logic [31:0] a, input logic [31:0] b);
      i_start = 1'b1;
      i_op    = op;
      i_cond  = cond;
      i_rs1   = a;
      i_op_b  = b;
      @(posedge clk);
      #1;
      i_start = 1'b0;
      // Words are captured, so the bus may change.
      i_rs1   = next_random();
      i_op_b  = next_random();
      issued++;
      await_done();
   endtask

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      logic [31:0] sel;
      logic [31:0] a;
      logic [31:0] b;
      rng_state = 32'he2b0_ee6e;
      issued    = 0;
      i_reset   = 1'b1;
      i_start   = 1'b0;
      i_rs1     = '0;
      i_op_b    = '0;
      i_op      = alu_pkg::OP_ADD;
      i_cond    = alu_pkg::CND_EQ;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      i_reset = 1'b0;

      // ==================================================================
      // Directed shift and compare corners.
      // ==================================================================
      issue_request(alu_pkg::OP_SLL, alu_pkg::CND_EQ, 32'h0000_0003, 32'd31);
      issue_request(alu_pkg::OP_SLL, alu_pkg::CND_NE, 32'h1234_5678, 32'hFFFF_FFE0);
      issue_request(alu_pkg::OP_SRL, alu_pkg::CND_LT, 32'hF000_0000, 32'd31);
      issue_request(alu_pkg::OP_SRA, alu_pkg::CND_GE, 32'h8000_0001, 32'd31);
      issue_request(alu_pkg::OP_SRA, alu_pkg::CND_LTU, 32'h8765_4321, 32'd0);
      issue_request(alu_pkg::OP_SRA, alu_pkg::CND_GEU, 32'h9000_0000, 32'd4);
      for (int i = 0; i < 6; i++) begin
         issue_request(alu_pkg::OP_SUB, cond_from_index(i), 32'h8000_0005, 32'h8000_0005);
         issue_request(alu_pkg::OP_SLT, cond_from_index(i), 32'h0000_0005, 32'h8000_0005);
         issue_request(alu_pkg::OP_SLTU, cond_from_index(i), 32'h8000_0005, 32'h0000_0005);
      end

      // Idle gap, outputs must hold.
      repeat (5) @(posedge clk);
      #1;

      // ==================================================================
      // Random requests, issued back to back at done.
      // ==================================================================
      for (int t = 0; t < N_RANDOM; t++) begin
         sel = next_random();
         a   = next_random();
         b   = next_random();
         case (sel[31:29])
            3'd0:    b = a;
            3'd1:    b = a ^ 32'h8000_0000;
            3'd2:    b[4:0] = 5'd31;
            3'd3:    b[4:0] = 5'd0;
            default: ;
         endcase
         issue_request(op_from_index(sel[27:20] % 10), cond_from_index(sel[19:12] % 6), a, b);
      end

      repeat (3) @(posedge clk);
      $display("%0d tests run, %0d passed, %0d failed", issued, pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt == issued)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: sources.f
rtl/alu_pkg.sv
rtl/operand_serializer.sv
rtl/alu_sequencer.sv
rtl/ser_add.sv
rtl/ser_shift.sv
rtl/serial_alu.sv
rtl/result_collector.sv
rtl/serial_alu_top.sv
sim/alu_checker.sv
sim/tb_serial_alu.sv
